/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := csr_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := verilog/csr_config.svh

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail from the simulation output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* src.f */
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_access_if.sv
verilog/csr_decoder.sv
verilog/csr_counters.sv
verilog/csr_file.sv
verilog/csr_top.sv
tests/csr_tb.sv

/* tests/csr_tb.sv */
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_tb;

  localparam int NUM_CYCLES = 2000;
  localparam int TIMEOUT    = 2 * NUM_CYCLES;
  localparam int NCNT       = `CSR_HPM_NUM + 2;

  // DUT ports
  logic                       clk;
  logic                       rst;
  logic                       instr_valid_i;
  logic [31:0]                instr_i;
  logic [31:0]                rs1_data_i;
  logic [31:0]                pc_i;
  logic                       retire_i;
  logic [`CSR_HPM_EVENTS-1:0] event_i;
  logic [31:0]                rd_data_o;
  logic                       rd_we_o;
  logic                       illegal_o;
  logic                       redirect_o;
  logic [31:0]                redirect_pc_o;
  logic [1:0]                 level_o;

  // reference model state
  logic [1:0]                 m_level;
  logic [1:0]                 m_mpp;
  logic                       m_spp;
  logic [31:0]                m_stvec, m_sscratch, m_sepc, m_scause;
  logic [31:0]                m_medeleg, m_mtvec, m_mscratch, m_mepc, m_mcause;
  logic [31:0]                m_inhibit;
  logic [`CSR_HPM_EVENTS-1:0] m_event [`CSR_HPM_NUM];
  // mcycle, minstret, then hpm counters
  logic [31:0]                m_cnt [NCNT];

  // expected outputs and pending update for this cycle
  logic                       e_rd_we, e_illegal, e_redirect;
  logic                       e_trap, e_to_s, e_mret, e_sret, e_we;
  logic [31:0]                e_rd_data, e_redirect_pc, e_cause, e_wval;
  logic [11:0]                e_addr;

  int errors      = 0;
  int checks      = 0;
  int cycle_count = 0;

  csr_top DUT (
    .clk           (clk),
    .rst           (rst),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data_i),
    .pc_i          (pc_i),
    .retire_i      (retire_i),
    .event_i       (event_i),
    .rd_data_o     (rd_data_o),
    .rd_we_o       (rd_we_o),
    .illegal_o     (illegal_o),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o),
    .level_o       (level_o)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_model();
    m_level    = 2'b11;
    m_mpp      = 2'b00;
    m_spp      = 1'b0;
    m_stvec    = '0;
    m_sscratch = '0;
    m_sepc     = '0;
    m_scause   = '0;
    m_medeleg  = '0;
    m_mtvec    = `CSR_RESET_TVEC;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_inhibit  = '0;
    for (int j = 0; j < `CSR_HPM_NUM; j++) begin
      m_event[j] = '0;
    end
    for (int k = 0; k < NCNT; k++) begin
      m_cnt[k] = '0;
    end
  endtask

  // read view of a supported address, ok low if unsupported
  function automatic logic [31:0] read_csr(input logic [11:0] a, output logic ok);
    logic [31:0] v;
    v  = '0;
    ok = 1'b1;
    case (a)
      // sstatus shows SPP only
      12'h100: v[8] = m_spp;
      12'h105: v = m_stvec;
      12'h140: v = m_sscratch;
      12'h141: v = m_sepc;
      12'h142: v = m_scause;
      12'h300: begin
        v[8]     = m_spp;
        v[12:11] = m_mpp;
      end
      12'h302: v = m_medeleg;
      12'h305: v = m_mtvec;
      12'h320: v = m_inhibit;
      12'h323, 12'h324, 12'h325, 12'h326: v = 32'(m_event[int'(a - 12'h323)]);
      12'h340: v = m_mscratch;
      12'h341: v = m_mepc;
      12'h342: v = m_mcause;
      12'hB00: v = m_cnt[0];
      12'hB02: v = m_cnt[1];
      12'hB03, 12'hB04, 12'hB05, 12'hB06: v = m_cnt[int'(a - 12'hB01)];
      // single hart, id zero
      12'hF14: v = '0;
      default: ok = 1'b0;
    endcase
    return v;
  endfunction

  // position in the counter array, -1 for other addresses
  function automatic int counter_index(input logic [11:0] a);
    if (a == 12'hB00) return 0;
    if (a == 12'hB02) return 1;
    if (a >= 12'hB03 && a <= 12'hB06) return int'(a - 12'hB01);
    return -1;
  endfunction

  task automatic write_csr(input logic [11:0] a, input logic [31:0] v);
    case (a)
      12'h100: m_spp = v[8];
      12'h300: begin
        m_spp = v[8];
        // reserved MPP value is ignored
        if (v[12:11] != 2'b10) m_mpp = v[12:11];
      end
      // tvec MODE bits read zero
      12'h105: m_stvec    = {v[31:2], 2'b00};
      12'h305: m_mtvec    = {v[31:2], 2'b00};
      12'h140: m_sscratch = v;
      12'h141: m_sepc     = v;
      12'h142: m_scause   = v;
      12'h302: m_medeleg  = v;
      12'h340: m_mscratch = v;
      12'h341: m_mepc     = v;
      12'h342: m_mcause   = v;
      // CY, IR and hpm bits, TM reads zero
      12'h320: m_inhibit  = v & (((32'd1 << (`CSR_HPM_NUM + 3)) - 32'd4) | 32'd1);
      12'h323, 12'h324, 12'h325, 12'h326:
        m_event[int'(a - 12'h323)] = v[`CSR_HPM_EVENTS-1:0];
      default: ;
    endcase
  endtask

  // expected outputs from current model state and inputs
  task automatic evaluate_model();
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [4:0]  rd, rs1f;
    logic [11:0] a;
    logic        is_csr, ren, wen, ok, bad;
    logic        is_ecall, is_ebreak, is_mret, is_sret;
    logic [31:0] rv, opnd;
    opc       = instr_i[6:0];
    f3        = instr_i[14:12];
    rd        = instr_i[11:7];
    rs1f      = instr_i[19:15];
    a         = instr_i[31:20];
    is_csr    = (opc == 7'h73) && (f3[1:0] != 2'b00);
    is_ecall  = (instr_i == 32'h0000_0073);
    is_ebreak = (instr_i == 32'h0010_0073);
    is_mret   = (instr_i == 32'h3020_0073);
    is_sret   = (instr_i == 32'h1020_0073);
    rv        = read_csr(a, ok);
    // CSRRW to x0 reads nothing, set or clear with zero mask writes nothing
    ren       = is_csr && ((f3[1:0] != 2'b01) || (rd != 5'd0));
    wen       = is_csr && ((f3[1:0] == 2'b01) || (rs1f != 5'd0));
    if (is_csr) begin
      bad = !ok || (a[9:8] > m_level) || (wen && (a[11:10] == 2'b11));
    end else begin
      bad = !(is_ecall || is_ebreak || is_mret || is_sret)
            || (is_sret && (m_level == 2'b00))
            || (is_mret && (m_level != 2'b11));
    end
    e_illegal = instr_valid_i && bad;
    e_trap    = e_illegal || (instr_valid_i && (is_ecall || is_ebreak));
    e_mret    = instr_valid_i && !bad && is_mret;
    e_sret    = instr_valid_i && !bad && is_sret;
    if (e_illegal) e_cause = 32'd2;
    else if (is_ebreak) e_cause = 32'd3;
    else if (m_level == 2'b00) e_cause = 32'd8;
    else if (m_level == 2'b01) e_cause = 32'd9;
    else e_cause = 32'd11;
    // delegation only from below M
    e_to_s = (m_level != 2'b11) && m_medeleg[e_cause[4:0]];
    opnd   = f3[2] ? {27'd0, rs1f} : rs1_data_i;
    case (f3[1:0])
      2'b10:   e_wval = rv | opnd;
      2'b11:   e_wval = rv & ~opnd;
      default: e_wval = opnd;
    endcase
    e_we       = instr_valid_i && !bad && is_csr && wen;
    e_addr     = a;
    e_rd_we    = instr_valid_i && is_csr && ren && !bad;
    e_rd_data  = rv;
    e_redirect = e_trap || e_mret || e_sret;
    if (e_trap) e_redirect_pc = e_to_s ? m_stvec : m_mtvec;
    else if (e_mret) e_redirect_pc = m_mepc;
    else if (e_sret) e_redirect_pc = m_sepc;
    else e_redirect_pc = '0;
  endtask

  // state change at the rising edge
  task automatic commit_model();
    logic inc, inh;
    int   idx;
    idx = e_we ? counter_index(e_addr) : -1;
    // counters use inhibit and selections from before this edge
    for (int k = 0; k < NCNT; k++) begin
      if (k == 0) inc = 1'b1;
      else if (k == 1) inc = retire_i;
      else inc = |(m_event[k-2] & event_i);
      if (k == 0) inh = m_inhibit[0];
      else if (k == 1) inh = m_inhibit[2];
      else inh = m_inhibit[k+1];
      // software write beats increment
      if (idx == k) m_cnt[k] = e_wval;
      else if (inc && !inh) m_cnt[k] = m_cnt[k] + 32'd1;
    end
    if (e_trap) begin
      if (e_to_s) begin
        m_spp    = (m_level == 2'b01);
        m_sepc   = pc_i;
        m_scause = e_cause;
        m_level  = 2'b01;
      end else begin
        m_mpp    = m_level;
        m_mepc   = pc_i;
        m_mcause = e_cause;
        m_level  = 2'b11;
      end
    end else if (e_mret) begin
      m_level = m_mpp;
      m_mpp   = 2'b00;
    end else if (e_sret) begin
      m_level = m_spp ? 2'b01 : 2'b00;
      m_spp   = 1'b0;
    end else if (e_we) begin
      write_csr(e_addr, e_wval);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and checks
  ////////////////////////////////////////////////////////////////////////////

  // heavy on scratch, epc, tvec and medeleg
  function automatic logic [11:0] pick_address();
    int unsigned r;
    r = $urandom_range(0, 99);
    if (r < 50) begin
      case (r % 7)
        0: return 12'h140;
        1: return 12'h340;
        2: return 12'h141;
        3: return 12'h341;
        4: return 12'h105;
        5: return 12'h305;
        default: return 12'h302;
      endcase
    end else if (r < 85) begin
      case (r % 16)
        0: return 12'h100;
        1: return 12'h142;
        2: return 12'h300;
        3: return 12'h342;
        4: return 12'h320;
        5: return 12'h323;
        6: return 12'h324;
        7: return 12'h325;
        8: return 12'h326;
        9: return 12'hB00;
        10: return 12'hB02;
        11: return 12'hB03;
        12: return 12'hB04;
        13: return 12'hB05;
        14: return 12'hB06;
        default: return 12'hF14;
      endcase
    end
    // unsupported
    case (r % 8)
      0: return 12'h000;
      1: return 12'h104;
      2: return 12'h301;
      3: return 12'h344;
      4: return 12'hC00;
      5: return 12'hB01;
      6: return 12'h7C0;
      default: return 12'h321;
    endcase
  endfunction

  task automatic drive_stimulus();
    int unsigned r;
    logic [2:0]  f3;
    r             = $urandom_range(0, 99);
    instr_valid_i = 1'b1;
    rs1_data_i    = $urandom;
    pc_i          = $urandom & 32'hFFFF_FFFC;
    retire_i      = 1'($urandom_range(0, 1));
    event_i       = `CSR_HPM_EVENTS'($urandom);
    // Zicsr funct3 from 1, 2, 3, 5, 6, 7
    f3 = 3'($urandom_range(1, 6));
    if (f3 >= 3'd4) f3 = f3 + 3'd1;
    if (r < 8) begin
      instr_valid_i = 1'b0;
      instr_i       = $urandom;
    end else if (r < 62) begin
      instr_i = {pick_address(), 5'($urandom), f3, 5'($urandom), 7'h73};
    end else if (r < 72) begin
      instr_i = 32'h0000_0073;
    end else if (r < 77) begin
      instr_i = 32'h0010_0073;
    end else if (r < 85) begin
      instr_i = 32'h3020_0073;
    end else if (r < 93) begin
      instr_i = 32'h1020_0073;
    end else if (r < 97) begin
      // reserved funct3 in SYSTEM space
      instr_i = {17'($urandom), 3'b100, 5'($urandom), 7'h73};
    end else begin
      // not a SYSTEM opcode at all
      instr_i = {25'($urandom), 7'h33};
    end
  endtask

  task automatic compare_signal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h (cycle %0d, instr %h)",
               name, got, exp, cycle_count, instr_i);
    end
  endtask

  task automatic check_outputs();
    compare_signal("rd_we_o", 32'(rd_we_o), 32'(e_rd_we));
    compare_signal("illegal_o", 32'(illegal_o), 32'(e_illegal));
    compare_signal("redirect_o", 32'(redirect_o), 32'(e_redirect));
    compare_signal("level_o", 32'(level_o), 32'(m_level));
    // data only matters where it is consumed
    if (e_rd_we) compare_signal("rd_data_o", rd_data_o, e_rd_data);
    if (e_redirect) compare_signal("redirect_pc_o", redirect_pc_o, e_redirect_pc);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(89));
    clk           = 1'b0;
    rst           = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    rs1_data_i    = '0;
    pc_i          = '0;
    retire_i      = 1'b0;
    event_i       = '0;
    reset_model();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_CYCLES; i++) begin
      drive_stimulus();
      // outputs settle well before the next rising edge
      #2;
      evaluate_model();
      check_outputs();
      @(posedge clk);
      commit_model();
      @(negedge clk);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verilog/csr_access_if.sv */
`timescale 1ns/1ps
`include "csr_config.svh"

// one decoded request per cycle, no handshake
interface csr_access_if import csr_pkg::*; ();

  // request, valid only in the cycle of the instruction
  logic                 valid;
  csr_ctl_t             ctl;
  // rs1 value
  logic [`CSR_XLEN-1:0] wdata;
  // pc of the instruction, for epc
  logic [`CSR_XLEN-1:0] pc;
  // old register value back to the register file
  logic [`CSR_XLEN-1:0] rdata;

  // decoder side
  modport dec (
    output valid, ctl, wdata, pc
  );

  // register file side, always accepts
  modport rf (
    input  valid, ctl, wdata, pc,
    output rdata
  );

endinterface

/* verilog/csr_config.svh */
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// data path
////////////////////////////////////////////////////////////////////////////

// register and data width
`define CSR_XLEN 32

////////////////////////////////////////////////////////////////////////////
// hardware performance monitor
////////////////////////////////////////////////////////////////////////////

// event counters, starting at mhpmcounter3
`define CSR_HPM_NUM 4
// width of the event input vector
`define CSR_HPM_EVENTS 8
// all counters: mcycle, minstret, then the event counters
`define CSR_CNT_NUM (`CSR_HPM_NUM + 2)
// index width into the counter array
`define CSR_CNT_IDXW $clog2(`CSR_CNT_NUM)

// trap vector after reset, loaded into mtvec
`define CSR_RESET_TVEC 32'h0000_0100

`endif

/* verilog/csr_counters.sv */
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_counters (
  input  logic                                        clk,
  input  logic                                        rst,
  // per counter inhibit, mcycle bit 0, minstret bit 1, hpm from bit 2
  input  logic [`CSR_CNT_NUM-1:0]                     inhibit_i,
  // event selection per hpm counter
  input  logic [`CSR_HPM_NUM-1:0][`CSR_HPM_EVENTS-1:0] sel_i,
  input  logic [`CSR_HPM_EVENTS-1:0]                  event_i,
  input  logic                                        retire_i,
  // software write
  input  logic                                        wr_en_i,
  input  logic [`CSR_CNT_IDXW-1:0]                    wr_idx_i,
  input  logic [`CSR_XLEN-1:0]                        wr_data_i,
  // counter values for reads
  output logic [`CSR_CNT_NUM-1:0][`CSR_XLEN-1:0]      cnt_o
);

  localparam int CNT_W = `CSR_CNT_IDXW;

  ////////////////////////////////////////////////////////////////////////////
  // increment conditions
  ////////////////////////////////////////////////////////////////////////////

  logic [`CSR_CNT_NUM-1:0] inc;

  always_comb begin
    // mcycle counts every edge
    inc[0] = 1'b1;
    // minstret on retire strobe
    inc[1] = retire_i;
    // hpm counter on any selected event
    for (int j = 0; j < `CSR_HPM_NUM; j++) begin
      inc[2+j] = |(sel_i[j] & event_i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // counter registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_o <= '0;
    end else begin
      for (int k = 0; k < `CSR_CNT_NUM; k++) begin
        // software write wins over increment
        if (wr_en_i && (wr_idx_i == CNT_W'(k))) begin
          cnt_o[k] <= wr_data_i;
        end else if (inc[k] && !inhibit_i[k]) begin
          cnt_o[k] <= cnt_o[k] + `CSR_XLEN'd1;
        end
      end
    end
  end

endmodule

/* verilog/csr_decoder.sv */
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_decoder import csr_pkg::*; (
  input  logic                 instr_valid_i,
  input  logic [31:0]          instr_i,
  input  logic [`CSR_XLEN-1:0] rs1_data_i,
  input  logic [`CSR_XLEN-1:0] pc_i,
  csr_access_if.dec            req
);

  // SYSTEM major opcode
  localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
  // full encodings of the privileged instructions
  localparam logic [31:0] INSN_ECALL  = 32'h0000_0073;
  localparam logic [31:0] INSN_EBREAK = 32'h0010_0073;
  localparam logic [31:0] INSN_SRET   = 32'h1020_0073;
  localparam logic [31:0] INSN_MRET   = 32'h3020_0073;

  // instruction fields
  logic [2:0] funct3;
  logic [4:0] rd;
  logic [4:0] rs1;
  csr_ctl_t   ctl;

  assign funct3 = instr_i[14:12];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];

  always_comb begin
    // anything not matched below is invalid
    ctl.op   = CSR_NONE;
    ctl.src  = SRC_RS1;
    ctl.imm  = rs1;
    ctl.addr = csr_addr_t'(instr_i[31:20]);
    ctl.ren  = 1'b0;
    ctl.wen  = 1'b0;
    ctl.priv = PRIV_INVALID;
    if (instr_i[6:0] == OPC_SYSTEM) begin
      case (funct3)
        3'b000: begin
          // privileged group, whole word compared
          case (instr_i)
            INSN_ECALL:  ctl.priv = PRIV_ECALL;
            INSN_EBREAK: ctl.priv = PRIV_EBREAK;
            INSN_MRET:   ctl.priv = PRIV_MRET;
            INSN_SRET:   ctl.priv = PRIV_SRET;
            default:     ctl.priv = PRIV_INVALID;
          endcase
        end
        // reserved funct3
        3'b100: ctl.priv = PRIV_INVALID;
        default: begin
          // Zicsr, op encoding equals funct3[1:0]
          ctl.priv = PRIV_NONE;
          ctl.op   = csr_op_t'(funct3[1:0]);
          ctl.src  = funct3[2] ? SRC_IMM : SRC_RS1;
          // CSRRW to x0 has no read side effect
          ctl.ren  = (ctl.op != CSR_WRITE) || (rd != 5'd0);
          // set or clear with zero mask writes nothing
          ctl.wen  = (ctl.op == CSR_WRITE) || (rs1 != 5'd0);
        end
      endcase
    end
  end

  // request goes out in the same cycle
  assign req.valid = instr_valid_i;
  assign req.ctl   = ctl;
  assign req.wdata = rs1_data_i;
  assign req.pc    = pc_i;

endmodule

/* verilog/csr_file.sv */
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_file import csr_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  csr_access_if.rf                  req,
  input  logic                      retire_i,
  input  logic [`CSR_HPM_EVENTS-1:0] event_i,
  output logic                      rd_we_o,
  output logic                      illegal_o,
  output logic                      redirect_o,
  output logic [`CSR_XLEN-1:0]      redirect_pc_o,
  output level_t                    level_o
);

  localparam int XLEN  = `CSR_XLEN;
  localparam int CNT_W = `CSR_CNT_IDXW;
  localparam int HPM_W = $clog2(`CSR_HPM_NUM);

  // state
  level_t            level;
  level_t            mpp;
  logic              spp;
  logic [XLEN-1:0]   stvec, sscratch, sepc, scause;
  logic [XLEN-1:0]   medeleg, mtvec, mscratch, mepc, mcause;
  logic [XLEN-1:0]   mcountinhibit;
  logic [`CSR_HPM_NUM-1:0][`CSR_HPM_EVENTS-1:0] mhpmevent;
  logic [`CSR_CNT_NUM-1:0][XLEN-1:0]            cnt;

  // read side
  logic [XLEN-1:0]   rd_val;
  logic              supported;
  logic              is_cnt;
  logic [CNT_W-1:0]  cnt_idx;
  logic [HPM_W-1:0]  ev_idx;
  // checks and traps
  logic              is_csr, csr_bad, priv_bad, illegal;
  logic              trap, to_s, do_mret, do_sret, csr_we;
  cause_t            cause;
  logic [XLEN-1:0]   operand, wval;
  logic [`CSR_CNT_NUM-1:0] inhibit;

  ////////////////////////////////////////////////////////////////////////////
  // read mux and address map
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_val    = '0;
    supported = 1'b1;
    is_cnt    = 1'b0;
    cnt_idx   = '0;
    // mhpmevent3 maps to entry 0
    ev_idx    = HPM_W'(req.ctl.addr[4:0] - 5'd3);
    case (req.ctl.addr)
      // S view of mstatus, SPP only
      CSR_SSTATUS:       rd_val[8] = spp;
      CSR_STVEC:         rd_val = stvec;
      CSR_SSCRATCH:      rd_val = sscratch;
      CSR_SEPC:          rd_val = sepc;
      CSR_SCAUSE:        rd_val = scause;
      CSR_MSTATUS: begin
        rd_val[8]     = spp;
        rd_val[12:11] = mpp;
      end
      CSR_MEDELEG:       rd_val = medeleg;
      CSR_MTVEC:         rd_val = mtvec;
      CSR_MSCRATCH:      rd_val = mscratch;
      CSR_MEPC:          rd_val = mepc;
      CSR_MCAUSE:        rd_val = mcause;
      CSR_MCOUNTINHIBIT: rd_val = mcountinhibit;
      CSR_MHPMEVENT3, CSR_MHPMEVENT4, CSR_MHPMEVENT5, CSR_MHPMEVENT6:
        rd_val = XLEN'(mhpmevent[ev_idx]);
      CSR_MCYCLE: begin
        is_cnt = 1'b1;
        rd_val = cnt[0];
      end
      CSR_MINSTRET: begin
        is_cnt  = 1'b1;
        cnt_idx = CNT_W'(1);
        rd_val  = cnt[1];
      end
      CSR_MHPMCOUNTER3, CSR_MHPMCOUNTER4, CSR_MHPMCOUNTER5, CSR_MHPMCOUNTER6: begin
        // mhpmcounter3 is entry 2
        is_cnt  = 1'b1;
        cnt_idx = CNT_W'(req.ctl.addr[4:0] - 5'd1);
        rd_val  = cnt[cnt_idx];
      end
      // single hart
      CSR_MHARTID:       rd_val = '0;
      default:           supported = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // access checks and trap decision
  ////////////////////////////////////////////////////////////////////////////

  assign is_csr  = (req.ctl.op != CSR_NONE);
  // unsupported, level too low, or write to read-only space
  assign csr_bad = is_csr && (!supported
                   || (level_t'(req.ctl.addr[9:8]) > level)
                   || (req.ctl.wen && (req.ctl.addr[11:10] == 2'b11)));

  always_comb begin
    case (req.ctl.priv)
      PRIV_INVALID: priv_bad = 1'b1;
      PRIV_SRET:    priv_bad = (level == LVL_U);
      PRIV_MRET:    priv_bad = (level != LVL_M);
      default:      priv_bad = 1'b0;
    endcase
  end

  assign illegal = req.valid && (csr_bad || priv_bad);
  assign trap    = illegal || (req.valid
                   && ((req.ctl.priv == PRIV_ECALL) || (req.ctl.priv == PRIV_EBREAK)));
  assign do_mret = req.valid && !illegal && (req.ctl.priv == PRIV_MRET);
  assign do_sret = req.valid && !illegal && (req.ctl.priv == PRIV_SRET);

  always_comb begin
    if (illegal) begin
      cause = CAUSE_ILLEGAL;
    end else if (req.ctl.priv == PRIV_EBREAK) begin
      cause = CAUSE_BREAKPOINT;
    end else begin
      case (level)
        LVL_U:   cause = CAUSE_ECALL_U;
        LVL_S:   cause = CAUSE_ECALL_S;
        default: cause = CAUSE_ECALL_M;
      endcase
    end
  end

  // never delegate a trap taken in M
  assign to_s = (level != LVL_M) && medeleg[cause[4:0]];

  ////////////////////////////////////////////////////////////////////////////
  // Zicsr read-modify-write
  ////////////////////////////////////////////////////////////////////////////

  assign operand = (req.ctl.src == SRC_IMM) ? XLEN'(req.ctl.imm) : req.wdata;

  always_comb begin
    case (req.ctl.op)
      CSR_SET:   wval = rd_val | operand;
      CSR_CLEAR: wval = rd_val & ~operand;
      default:   wval = operand;
    endcase
  end

  assign csr_we = req.valid && !illegal && is_csr && req.ctl.wen;

  // outputs, all combinational
  assign req.rdata  = rd_val;
  assign rd_we_o    = req.valid && is_csr && req.ctl.ren && !illegal;
  assign illegal_o  = illegal;
  assign redirect_o = trap || do_mret || do_sret;
  assign level_o    = level;

  always_comb begin
    if (trap) begin
      redirect_pc_o = to_s ? stvec : mtvec;
    end else if (do_mret) begin
      redirect_pc_o = mepc;
    end else if (do_sret) begin
      redirect_pc_o = sepc;
    end else begin
      redirect_pc_o = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      level         <= LVL_M;
      mpp           <= LVL_U;
      spp           <= 1'b0;
      stvec         <= '0;
      sscratch      <= '0;
      sepc          <= '0;
      scause        <= '0;
      medeleg       <= '0;
      mtvec         <= `CSR_RESET_TVEC;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mcountinhibit <= '0;
      mhpmevent     <= '0;
    end else if (trap) begin
      if (to_s) begin
        level  <= LVL_S;
        spp    <= (level == LVL_S);
        sepc   <= req.pc;
        scause <= cause;
      end else begin
        level  <= LVL_M;
        mpp    <= level;
        mepc   <= req.pc;
        mcause <= cause;
      end
    end else if (do_mret) begin
      // MPP drops to U after return
      level <= mpp;
      mpp   <= LVL_U;
    end else if (do_sret) begin
      level <= spp ? LVL_S : LVL_U;
      spp   <= 1'b0;
    end else if (csr_we) begin
      case (req.ctl.addr)
        CSR_SSTATUS:  spp <= wval[8];
        CSR_MSTATUS: begin
          spp <= wval[8];
          // reserved level keeps old MPP
          if (wval[12:11] != 2'b10) begin
            mpp <= level_t'(wval[12:11]);
          end
        end
        // MODE bits read-only zero
        CSR_STVEC:    stvec    <= {wval[XLEN-1:2], 2'b00};
        CSR_MTVEC:    mtvec    <= {wval[XLEN-1:2], 2'b00};
        CSR_SSCRATCH: sscratch <= wval;
        CSR_SEPC:     sepc     <= wval;
        CSR_SCAUSE:   scause   <= wval;
        CSR_MEDELEG:  medeleg  <= wval;
        CSR_MSCRATCH: mscratch <= wval;
        CSR_MEPC:     mepc     <= wval;
        CSR_MCAUSE:   mcause   <= wval;
        // CY, IR and hpm bits, TM stays zero
        CSR_MCOUNTINHIBIT: begin
          mcountinhibit <= '0;
          mcountinhibit[0] <= wval[0];
          mcountinhibit[`CSR_HPM_NUM+2:2] <= wval[`CSR_HPM_NUM+2:2];
        end
        CSR_MHPMEVENT3, CSR_MHPMEVENT4, CSR_MHPMEVENT5, CSR_MHPMEVENT6:
          mhpmevent[ev_idx] <= wval[`CSR_HPM_EVENTS-1:0];
        default: ;
      endcase
    end
  end

  // compact inhibit order for the counter array
  assign inhibit = {mcountinhibit[`CSR_HPM_NUM+2:3], mcountinhibit[2], mcountinhibit[0]};

  csr_counters u_counters (
    .clk       (clk),
    .rst       (rst),
    .inhibit_i (inhibit),
    .sel_i     (mhpmevent),
    .event_i   (event_i),
    .retire_i  (retire_i),
    .wr_en_i   (csr_we && is_cnt),
    .wr_idx_i  (cnt_idx),
    .wr_data_i (wval),
    .cnt_o     (cnt)
  );

endmodule

/* verilog/csr_pkg.sv */
`include "csr_config.svh"

package csr_pkg;

  //////////////////////////////////////////////////////////////////////////
  // privilege and instruction control
  //////////////////////////////////////////////////////////////////////////

  // privilege level, same encoding as address bits 9:8
  typedef enum logic [1:0] {
    LVL_U = 2'b00,
    LVL_S = 2'b01,
    LVL_R = 2'b10,
    LVL_M = 2'b11
  } level_t;

  // encoding follows funct3[1:0] of the Zicsr instructions
  typedef enum logic [1:0] {
    CSR_NONE  = 2'b00,
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_t;

  // operand source, funct3[2]
  typedef enum logic {
    SRC_RS1 = 1'b0,
    SRC_IMM = 1'b1
  } csr_src_t;

  // supported addresses
  // bits 11:10 == 2'b11 is read-only, bits 9:8 lowest level allowed
  typedef enum logic [11:0] {
    CSR_SSTATUS       = 12'h100,
    CSR_STVEC         = 12'h105,
    CSR_SSCRATCH      = 12'h140,
    CSR_SEPC          = 12'h141,
    CSR_SCAUSE        = 12'h142,
    CSR_MSTATUS       = 12'h300,
    CSR_MEDELEG       = 12'h302,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MHPMEVENT3    = 12'h323,
    CSR_MHPMEVENT4    = 12'h324,
    CSR_MHPMEVENT5    = 12'h325,
    CSR_MHPMEVENT6    = 12'h326,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MHPMCOUNTER3  = 12'hB03,
    CSR_MHPMCOUNTER4  = 12'hB04,
    CSR_MHPMCOUNTER5  = 12'hB05,
    CSR_MHPMCOUNTER6  = 12'hB06,
    CSR_MHARTID       = 12'hF14
  } csr_addr_t;

  // exception codes, interrupt bit always clear
  typedef enum logic [`CSR_XLEN-1:0] {
    CAUSE_ILLEGAL    = `CSR_XLEN'd2,
    CAUSE_BREAKPOINT = `CSR_XLEN'd3,
    CAUSE_ECALL_U    = `CSR_XLEN'd8,
    CAUSE_ECALL_S    = `CSR_XLEN'd9,
    CAUSE_ECALL_M    = `CSR_XLEN'd11
  } cause_t;

  // privileged instruction kind
  typedef enum logic [2:0] {
    PRIV_NONE, PRIV_ECALL, PRIV_EBREAK, PRIV_MRET, PRIV_SRET, PRIV_INVALID
  } priv_t;

  // decoded request
  typedef struct packed {
    csr_op_t   op;
    csr_src_t  src;
    logic [4:0] imm;   // zimm or rs1 field
    csr_addr_t addr;
    logic      ren;    // read intent
    logic      wen;    // write intent
    priv_t     priv;
  } csr_ctl_t;

endpackage

/* verilog/csr_top.sv */
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_top import csr_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  // instruction from the core
  input  logic                       instr_valid_i,
  input  logic [31:0]                instr_i,
  input  logic [`CSR_XLEN-1:0]       rs1_data_i,
  input  logic [`CSR_XLEN-1:0]       pc_i,
  // counter inputs
  input  logic                       retire_i,
  input  logic [`CSR_HPM_EVENTS-1:0] event_i,
  // register file write back
  output logic [`CSR_XLEN-1:0]       rd_data_o,
  output logic                       rd_we_o,
  // trap and return
  output logic                       illegal_o,
  output logic                       redirect_o,
  output logic [`CSR_XLEN-1:0]       redirect_pc_o,
  output level_t                     level_o
);

  // decoder to register file
  csr_access_if acc ();

  csr_decoder u_decoder (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data_i),
    .pc_i          (pc_i),
    .req           (acc.dec)
  );

  csr_file u_file (
    .clk           (clk),
    .rst           (rst),
    .req           (acc.rf),
    .retire_i      (retire_i),
    .event_i       (event_i),
    .rd_we_o       (rd_we_o),
    .illegal_o     (illegal_o),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o),
    .level_o       (level_o)
  );

  // old value back to the register file
  assign rd_data_o = acc.rdata;

endmodule
